/* flist.f */
logic/des_pkg.sv
logic/des_sbox_bank.sv
logic/des_round_function.sv
logic/des_key_schedule.sv
logic/des_round_engine.sv
logic/des_result_queue.sv
logic/des_crypt_top.sv
verification/des_crypt_tb.sv

/* logic/des_crypt_top.sv */
`timescale 1ns/100ps
`default_nettype none

module des_crypt_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic                 decrypt,
    input  des_pkg::des_key_t    key,
    input  des_pkg::des_block_t  block_in,
    input  logic                 pop,
    output logic                 busy,
    output des_pkg::des_result_t result,
    output logic                 empty,
    output logic                 full,
    output logic                 overflow
);
    import des_pkg::*;

    logic        push;
    des_result_t push_data;  // Engine output word

    des_round_engine u_engine (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .decrypt  (decrypt),
        .key      (key),
        .block_in (block_in),
        .busy     (busy),
        .push     (push),
        .result   (push_data)
    );

    des_result_queue u_queue (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .head      (result),
        .empty     (empty),
        .full      (full),
        .overflow  (overflow)
    );

endmodule

`default_nettype wire

/* logic/des_key_schedule.sv */
`timescale 1ns/100ps
`default_nettype none

module des_key_schedule (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 load,
    input  logic                 decrypt,
    input  des_pkg::des_key_t    key,
    input  logic                 step,
    input  logic [3:0]           round,
    output des_pkg::des_subkey_t subkey
);
    import des_pkg::*;

    logic [0:55] pc1_bits;
    logic [0:55] cd;
    logic [0:27] c_q;
    logic [0:27] d_q;
    logic        right_q;  // Rotate right when decrypting
    logic [1:0]  amount;

    function automatic logic [0:27] rotate(input logic [0:27] x, input logic [1:0] n,
                                           input logic to_right);
        if (to_right) begin
            return (x >> n) | (x << (28 - n));
        end
        return (x << n) | (x >> (28 - n));
    endfunction

    always_comb begin
        for (int i = 0; i < 56; i++) begin
            pc1_bits[i] = key[PC1_TABLE[i]];
        end
    end

    // Holding C(r+1) while encrypting, C(16-r) while decrypting
    assign amount = right_q ? SHIFT_TABLE[~round] : SHIFT_TABLE[round + 4'd1];

    always_ff @(posedge clk) begin
        if (rst) begin
            right_q <= 1'b0;
        end else if (load) begin
            right_q <= decrypt;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            if (decrypt) begin
                c_q <= pc1_bits[0:27];  // 28 total shifts bring C16 back to C0
                d_q <= pc1_bits[28:55];
            end else begin
                c_q <= rotate(pc1_bits[0:27], 2'd1, 1'b0);
                d_q <= rotate(pc1_bits[28:55], 2'd1, 1'b0);
            end
        end else if (step) begin
            c_q <= rotate(c_q, amount, right_q);
            d_q <= rotate(d_q, amount, right_q);
        end
    end

    assign cd = {c_q, d_q};

    always_comb begin
        for (int i = 0; i < 48; i++) begin
            subkey[i] = cd[PC2_TABLE[i]];
        end
    end

    // Engine only loads while idle
    a_load_step_excl: assert property (@(posedge clk) disable iff (rst) !(load && step));

endmodule

`default_nettype wire

/* logic/des_pkg.sv */
`default_nettype none

package des_pkg;

    // Index 0 is DES bit 1, the most significant bit
    typedef logic [0:63] des_block_t;
    typedef logic [0:63] des_key_t;    // Parity bits kept but unused
    typedef logic [0:31] des_half_t;
    typedef logic [0:47] des_subkey_t;

    typedef struct packed {
        des_block_t block;
        logic       decrypt;
    } des_result_t;

    localparam int DES_ROUNDS  = 16;
    localparam int QUEUE_DEPTH = 4;
    localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
    localparam int QCOUNT_W    = $clog2(QUEUE_DEPTH + 1);

    // Box, row from outer bits, column from inner bits
    localparam logic [3:0] SBOX_TABLE [0:7][0:3][0:15] = '{
        '{
            '{14,  4, 13,  1,  2, 15, 11,  8,  3, 10,  6, 12,  5,  9,  0,  7},
            '{ 0, 15,  7,  4, 14,  2, 13,  1, 10,  6, 12, 11,  9,  5,  3,  8},
            '{ 4,  1, 14,  8, 13,  6,  2, 11, 15, 12,  9,  7,  3, 10,  5,  0},
            '{15, 12,  8,  2,  4,  9,  1,  7,  5, 11,  3, 14, 10,  0,  6, 13}
        },
        '{
            '{15,  1,  8, 14,  6, 11,  3,  4,  9,  7,  2, 13, 12,  0,  5, 10},
            '{ 3, 13,  4,  7, 15,  2,  8, 14, 12,  0,  1, 10,  6,  9, 11,  5},
            '{ 0, 14,  7, 11, 10,  4, 13,  1,  5,  8, 12,  6,  9,  3,  2, 15},
            '{13,  8, 10,  1,  3, 15,  4,  2, 11,  6,  7, 12,  0,  5, 14,  9}
        },
        '{
            '{10,  0,  9, 14,  6,  3, 15,  5,  1, 13, 12,  7, 11,  4,  2,  8},
            '{13,  7,  0,  9,  3,  4,  6, 10,  2,  8,  5, 14, 12, 11, 15,  1},
            '{13,  6,  4,  9,  8, 15,  3,  0, 11,  1,  2, 12,  5, 10, 14,  7},
            '{ 1, 10, 13,  0,  6,  9,  8,  7,  4, 15, 14,  3, 11,  5,  2, 12}
        },
        '{
            '{ 7, 13, 14,  3,  0,  6,  9, 10,  1,  2,  8,  5, 11, 12,  4, 15},
            '{13,  8, 11,  5,  6, 15,  0,  3,  4,  7,  2, 12,  1, 10, 14,  9},
            '{10,  6,  9,  0, 12, 11,  7, 13, 15,  1,  3, 14,  5,  2,  8,  4},
            '{ 3, 15,  0,  6, 10,  1, 13,  8,  9,  4,  5, 11, 12,  7,  2, 14}
        },
        '{
            '{ 2, 12,  4,  1,  7, 10, 11,  6,  8,  5,  3, 15, 13,  0, 14,  9},
            '{14, 11,  2, 12,  4,  7, 13,  1,  5,  0, 15, 10,  3,  9,  8,  6},
            '{ 4,  2,  1, 11, 10, 13,  7,  8, 15,  9, 12,  5,  6,  3,  0, 14},
            '{11,  8, 12,  7,  1, 14,  2, 13,  6, 15,  0,  9, 10,  4,  5,  3}
        },
        '{
            '{12,  1, 10, 15,  9,  2,  6,  8,  0, 13,  3,  4, 14,  7,  5, 11},
            '{10, 15,  4,  2,  7, 12,  9,  5,  6,  1, 13, 14,  0, 11,  3,  8},
            '{ 9, 14, 15,  5,  2,  8, 12,  3,  7,  0,  4, 10,  1, 13, 11,  6},
            '{ 4,  3,  2, 12,  9,  5, 15, 10, 11, 14,  1,  7,  6,  0,  8, 13}
        },
        '{
            '{ 4, 11,  2, 14, 15,  0,  8, 13,  3, 12,  9,  7,  5, 10,  6,  1},
            '{13,  0, 11,  7,  4,  9,  1, 10, 14,  3,  5, 12,  2, 15,  8,  6},
            '{ 1,  4, 11, 13, 12,  3,  7, 14, 10, 15,  6,  8,  0,  5,  9,  2},
            '{ 6, 11, 13,  8,  1,  4, 10,  7,  9,  5,  0, 15, 14,  2,  3, 12}
        },
        '{
            '{13,  2,  8,  4,  6, 15, 11,  1, 10,  9,  3, 14,  5,  0, 12,  7},
            '{ 1, 15, 13,  8, 10,  3,  7,  4, 12,  5,  6, 11,  0, 14,  9,  2},
            '{ 7, 11,  4,  1,  9, 12, 14,  2,  0,  6, 10, 13, 15,  3,  5,  8},
            '{ 2,  1, 14,  7,  4, 10,  8, 13, 15, 12,  9,  0,  3,  5,  6, 11}
        }
    };

    // Permutation entries are DES bit positions minus one
    localparam logic [5:0] IP_TABLE [0:63] = '{
        57, 49, 41, 33, 25, 17,  9,  1,
        59, 51, 43, 35, 27, 19, 11,  3,
        61, 53, 45, 37, 29, 21, 13,  5,
        63, 55, 47, 39, 31, 23, 15,  7,
        56, 48, 40, 32, 24, 16,  8,  0,
        58, 50, 42, 34, 26, 18, 10,  2,
        60, 52, 44, 36, 28, 20, 12,  4,
        62, 54, 46, 38, 30, 22, 14,  6
    };

    localparam logic [5:0] FP_TABLE [0:63] = '{
        39,  7, 47, 15, 55, 23, 63, 31,
        38,  6, 46, 14, 54, 22, 62, 30,
        37,  5, 45, 13, 53, 21, 61, 29,
        36,  4, 44, 12, 52, 20, 60, 28,
        35,  3, 43, 11, 51, 19, 59, 27,
        34,  2, 42, 10, 50, 18, 58, 26,
        33,  1, 41,  9, 49, 17, 57, 25,
        32,  0, 40,  8, 48, 16, 56, 24
    };

    localparam logic [5:0] E_TABLE [0:47] = '{
        31,  0,  1,  2,  3,  4,
         3,  4,  5,  6,  7,  8,
         7,  8,  9, 10, 11, 12,
        11, 12, 13, 14, 15, 16,
        15, 16, 17, 18, 19, 20,
        19, 20, 21, 22, 23, 24,
        23, 24, 25, 26, 27, 28,
        27, 28, 29, 30, 31,  0
    };

    localparam logic [5:0] P_TABLE [0:31] = '{
        15,  6, 19, 20, 28, 11, 27, 16,
         0, 14, 22, 25,  4, 17, 30,  9,
         1,  7, 23, 13, 31, 26,  2,  8,
        18, 12, 29,  5, 21, 10,  3, 24
    };

    localparam logic [5:0] PC1_TABLE [0:55] = '{
        56, 48, 40, 32, 24, 16,  8,
         0, 57, 49, 41, 33, 25, 17,
         9,  1, 58, 50, 42, 34, 26,
        18, 10,  2, 59, 51, 43, 35,
        62, 54, 46, 38, 30, 22, 14,
         6, 61, 53, 45, 37, 29, 21,
        13,  5, 60, 52, 44, 36, 28,
        20, 12,  4, 27, 19, 11,  3
    };

    // Indexes into the 56-bit C and D pair
    localparam logic [5:0] PC2_TABLE [0:47] = '{
        13, 16, 10, 23,  0,  4,
         2, 27, 14,  5, 20,  9,
        22, 18, 11,  3, 25,  7,
        15,  6, 26, 19, 12,  1,
        40, 51, 30, 36, 46, 54,
        29, 39, 50, 44, 32, 47,
        43, 48, 38, 55, 33, 52,
        45, 41, 49, 35, 28, 31
    };

    localparam logic [1:0] SHIFT_TABLE [0:15] = '{
        1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1
    };

endpackage

`default_nettype wire

/* logic/des_result_queue.sv */
`timescale 1ns/100ps
`default_nettype none

module des_result_queue (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 push,
    input  des_pkg::des_result_t push_data,
    input  logic                 pop,
    output des_pkg::des_result_t head,
    output logic                 empty,
    output logic                 full,
    output logic                 overflow
);
    import des_pkg::*;

    des_result_t         mem [QUEUE_DEPTH];
    logic [QPTR_W-1:0]   wr_ptr;
    logic [QPTR_W-1:0]   rd_ptr;
    logic [QCOUNT_W-1:0] count;
    logic                do_push;
    logic                do_pop;

    function automatic logic [QPTR_W-1:0] next_ptr(input logic [QPTR_W-1:0] p);
        return (p == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign empty   = (count == '0);
    assign full    = (count == QCOUNT_W'(QUEUE_DEPTH));
    assign head    = mem[rd_ptr];
    assign do_pop  = pop && !empty;
    assign do_push = push && (!full || pop);  // Full slot frees on same edge

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            overflow <= push && !do_push;
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (rst)
        count <= QCOUNT_W'(QUEUE_DEPTH));

endmodule

`default_nettype wire

/* logic/des_round_engine.sv */
`timescale 1ns/100ps
`default_nettype none

module des_round_engine (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic                 decrypt,
    input  des_pkg::des_key_t    key,
    input  des_pkg::des_block_t  block_in,
    output logic                 busy,
    output logic                 push,
    output des_pkg::des_result_t result
);
    import des_pkg::*;

    localparam logic [3:0] LAST_ROUND = 4'(DES_ROUNDS - 1);

    des_half_t   l_q;
    des_half_t   r_q;
    logic        mode_q;
    logic [3:0]  round;
    logic        accept;
    des_subkey_t subkey;
    des_half_t   f_out;
    des_block_t  ip_block;
    des_block_t  preout;
    des_block_t  fp_block;

    assign accept = start && !busy;
    assign preout = {l_q ^ f_out, r_q};  // R16 L16 after the final swap

    always_comb begin
        for (int i = 0; i < 64; i++) begin
            ip_block[i] = block_in[IP_TABLE[i]];
            fp_block[i] = preout[FP_TABLE[i]];
        end
    end

    des_key_schedule u_key_schedule (
        .clk     (clk),
        .rst     (rst),
        .load    (accept),
        .decrypt (decrypt),
        .key     (key),
        .step    (busy),
        .round   (round),
        .subkey  (subkey)
    );

    des_round_function u_round_function (
        .right  (r_q),
        .subkey (subkey),
        .f_out  (f_out)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            push  <= 1'b0;
            round <= '0;
        end else begin
            push <= 1'b0;
            if (accept) begin
                busy  <= 1'b1;
                round <= '0;
            end else if (busy) begin
                round <= round + 4'd1;
                if (round == LAST_ROUND) begin
                    busy <= 1'b0;
                    push <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            l_q    <= ip_block[0:31];
            r_q    <= ip_block[32:63];
            mode_q <= decrypt;
        end else if (busy) begin
            l_q <= r_q;
            r_q <= l_q ^ f_out;
        end
        if (busy && round == LAST_ROUND) begin
            result.block   <= fp_block;
            result.decrypt <= mode_q;
        end
    end

    a_push_pulse: assert property (@(posedge clk) disable iff (rst) push |=> !push);

    // Counter steps 0 to 15 without skipping while busy
    a_round_walk: assert property (@(posedge clk) disable iff (rst)
        busy && round != LAST_ROUND |=> busy && round == $past(round) + 4'd1);

endmodule

`default_nettype wire

/* logic/des_round_function.sv */
`timescale 1ns/100ps
`default_nettype none

module des_round_function (
    input  des_pkg::des_half_t   right,
    input  des_pkg::des_subkey_t subkey,
    output des_pkg::des_half_t   f_out
);
    import des_pkg::*;

    des_subkey_t expanded;
    des_subkey_t mixed;
    des_half_t   sbox_out;

    always_comb begin
        for (int i = 0; i < 48; i++) begin
            expanded[i] = right[E_TABLE[i][4:0]];  // 32 to 48 bit expansion
        end
    end

    assign mixed = expanded ^ subkey;

    des_sbox_bank u_sbox_bank (
        .din  (mixed),
        .dout (sbox_out)
    );

    always_comb begin
        for (int i = 0; i < 32; i++) begin
            f_out[i] = sbox_out[P_TABLE[i][4:0]];
        end
    end

endmodule

`default_nettype wire

/* logic/des_sbox_bank.sv */
`timescale 1ns/100ps
`default_nettype none

module des_sbox_bank (
    input  des_pkg::des_subkey_t din,
    output des_pkg::des_half_t   dout
);
    import des_pkg::*;

    for (genvar b = 0; b < 8; b++) begin : g_box
        logic [0:5] grp;
        logic [1:0] row;
        logic [3:0] col;

        assign grp = din[6*b +: 6];
        assign row = {grp[0], grp[5]};  // Outer bits
        assign col = grp[1:4];
        assign dout[4*b +: 4] = SBOX_TABLE[b][row][col];
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

{ verilator --binary --assert -Wno-fatal -f flist.f --top-module des_crypt_tb -o des_sim \
    && ./obj_dir/des_sim; } > "$LOG" 2>&1 \
    || echo "Build or simulation ended with an error" >> "$LOG"

grep -q "Some tests failed" "$LOG" \
    && { echo "Simulation failed, see $LOG"; exit 1; }

grep -q "All tests passed" "$LOG" \
    && echo "Simulation passed" \
    || { echo "No pass result in $LOG"; exit 1; }

/* verification/des_crypt_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module des_crypt_tb;
    import des_pkg::*;

    localparam des_key_t   KEY_A = 64'h133457799BBCDFF1;
    localparam des_block_t PT_A  = 64'h0123456789ABCDEF;
    localparam des_block_t CT_A  = 64'h85E813540F0AB405;
    localparam des_block_t CT_Z  = 64'h8CA64DE9C1B123A7;  // Zero key, zero block
    localparam int         WAIT_LIMIT = 40;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic        start = 1'b0;
    logic        decrypt = 1'b0;
    des_key_t    key = '0;
    des_block_t  block_in = '0;
    logic        pop = 1'b0;
    logic        busy;
    des_result_t result;
    logic        empty;
    logic        full;
    logic        overflow;

    logic        chk_block = 1'b0;  // Strobes sampled by the assertions
    logic        chk_mode = 1'b0;
    logic        chk_empty = 1'b0;
    logic        chk_level = 1'b0;
    logic        lat_mode = 1'b0;
    des_block_t  exp_block = '0;
    logic        exp_mode = 1'b0;
    logic        exp_full = 1'b0;
    logic        exp_ovf = 1'b0;
    int          errors = 0;
    int          busy_cycles;
    integer      seed = 21;

    des_crypt_top dut (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .decrypt  (decrypt),
        .key      (key),
        .block_in (block_in),
        .pop      (pop),
        .busy     (busy),
        .result   (result),
        .empty    (empty),
        .full     (full),
        .overflow (overflow)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        if (rst || !busy) begin
            busy_cycles <= 0;
        end else begin
            busy_cycles <= busy_cycles + 1;
        end
    end

    task automatic report_fail(input string msg);
        errors++;
        $display("FAILED at %0t: %s", $time, msg);
    endtask

    a_reset_idle: assert property (@(posedge clk)
        $fell(rst) |-> !busy && !full && !overflow && empty)
        else report_fail("outputs not idle after reset");
    a_head_block: assert property (@(posedge clk) chk_block |-> !empty && result.block == exp_block)
        else report_fail("result block differs from expected");
    a_head_mode: assert property (@(posedge clk) chk_mode |-> !empty && result.decrypt == exp_mode)
        else report_fail("result decrypt flag differs from expected");
    a_latency: assert property (@(posedge clk) lat_mode && start && !busy |-> ##17 empty ##1 !empty)
        else report_fail("start to result latency is not 18 cycles");
    a_busy_len: assert property (@(posedge clk) disable iff (rst) $fell(busy) |-> busy_cycles == 16)
        else report_fail("busy not high for exactly 16 cycles");
    a_empty: assert property (@(posedge clk) chk_empty |-> empty)
        else report_fail("queue holds an unexpected entry");
    a_levels: assert property (@(posedge clk)
        chk_level |-> full == exp_full && overflow == exp_ovf)
        else report_fail("full or overflow level wrong");
    a_ovf_pulse: assert property (@(posedge clk) disable iff (rst) overflow |=> !overflow)
        else report_fail("overflow longer than one cycle");
    a_ovf_full: assert property (@(posedge clk) disable iff (rst) overflow |-> $past(full))
        else report_fail("overflow while queue not full");

    // Called right after a falling edge
    task automatic start_job(input des_key_t k, input des_block_t b, input logic d);
        start = 1'b1;
        key = k;
        block_in = b;
        decrypt = d;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_idle();
        for (int i = 0; i < WAIT_LIMIT && busy; i++) begin
            @(negedge clk);
        end
        if (busy) begin
            errors++;
            $display("Timeout at %0t: engine never left busy", $time);
        end
    endtask

    task automatic wait_result();
        for (int i = 0; i < WAIT_LIMIT && empty; i++) begin
            @(negedge clk);
        end
        if (empty) begin
            errors++;
            $display("Timeout at %0t: result never arrived in the queue", $time);
        end
    endtask

    task automatic pop_check(input des_block_t b, input logic d);
        exp_block = b;
        exp_mode = d;
        chk_block = 1'b1;
        chk_mode = 1'b1;
        pop = 1'b1;
        @(negedge clk);
        chk_block = 1'b0;
        chk_mode = 1'b0;
        pop = 1'b0;
    endtask

    task automatic pop_cipher(output des_block_t b);
        b = result.block;  // Stable at the falling edge
        exp_mode = 1'b0;
        chk_mode = 1'b1;
        pop = 1'b1;
        @(negedge clk);
        chk_mode = 1'b0;
        pop = 1'b0;
    endtask

    task automatic check_empty();
        chk_empty = 1'b1;
        @(negedge clk);
        chk_empty = 1'b0;
    endtask

    task automatic fill_step(input des_key_t k, input des_block_t b, input logic d,
                             input logic f, input logic o);
        start_job(k, b, d);
        wait_idle();
        @(negedge clk);  // Push lands on this edge
        exp_full = f;
        exp_ovf = o;
        chk_level = 1'b1;
        @(negedge clk);
        chk_level = 1'b0;
    endtask

    initial begin
        des_key_t   rnd_key;
        des_block_t rnd_blk;
        des_block_t cipher;

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        lat_mode = 1'b1;
        start_job(KEY_A, PT_A, 1'b0);
        lat_mode = 1'b0;
        wait_result();
        pop_check(CT_A, 1'b0);
        lat_mode = 1'b1;
        start_job('0, '0, 1'b0);
        lat_mode = 1'b0;
        wait_result();
        pop_check(CT_Z, 1'b0);

        start_job(KEY_A, CT_A, 1'b1);
        wait_result();
        pop_check(PT_A, 1'b1);
        start_job('0, CT_Z, 1'b1);
        wait_result();
        pop_check('0, 1'b1);

        for (int n = 0; n < 10; n++) begin
            rnd_key = {$random(seed), $random(seed)};
            rnd_blk = {$random(seed), $random(seed)};
            start_job(rnd_key, rnd_blk, 1'b0);
            wait_result();
            pop_cipher(cipher);
            start_job(rnd_key, cipher, 1'b1);
            wait_result();
            pop_check(rnd_blk, 1'b1);
        end

        // Second start lands mid-run
        start_job(KEY_A, PT_A, 1'b0);
        repeat (4) @(negedge clk);
        start_job('0, '0, 1'b1);
        wait_result();
        pop_check(CT_A, 1'b0);
        check_empty();
        repeat (20) @(negedge clk);
        check_empty();

        fill_step(KEY_A, PT_A, 1'b0, 1'b0, 1'b0);
        fill_step('0, '0, 1'b0, 1'b0, 1'b0);
        fill_step(KEY_A, CT_A, 1'b1, 1'b0, 1'b0);
        fill_step('0, CT_Z, 1'b1, 1'b1, 1'b0);
        fill_step(KEY_A, PT_A, 1'b1, 1'b1, 1'b1);
        pop_check(CT_A, 1'b0);
        pop_check(CT_Z, 1'b0);
        pop_check(PT_A, 1'b1);
        pop_check('0, 1'b1);
        check_empty();

        repeat (3) @(negedge clk);
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
